/* source/soc_pkg.sv */
package soc_pkg;

  // byte address width of the board bus
  localparam int addr_width = 12;

  // address map
  localparam logic [addr_width-1:0] load_base   = 12'h300; // first loaded word
  localparam logic [addr_width-1:0] io_led_addr = 12'h080; // io word, led byte
  localparam logic [addr_width-1:0] io_lcd_addr = 12'h081; // lcd byte

  // io window 0x080..0x0ff, matched as base plus mask
  localparam logic [addr_width-1:0] io_region      = 12'h080;
  localparam logic [addr_width-1:0] io_region_mask = 12'hf80;

  // loader
  localparam logic [15:0] end_mark = 16'h7fff; // ends a load, never stored

  // led matrix
  localparam int          row_count   = 9;
  localparam logic [15:0] scan_period = 16'd27000; // cycles per row
  localparam logic [15:0] gap_on      = 16'd100;   // dark lead-in of a row
  localparam logic [15:0] gap_off     = 16'd2000;  // dark tail of a row

  // one bus word, seen whole or as bytes[1] (high) / bytes[0] (low)
  typedef union packed {
    logic [15:0]     whole;
    logic [1:0][7:0] bytes;
  } bus_word_u;

endpackage

/* source/byte_bank_ram.sv */
`timescale 1ns/1ps

// one byte lane of main memory, even or odd bytes
module byte_bank_ram (
  input  logic                           sys_clk,
  input  logic                           wr,
  input  logic [soc_pkg::addr_width-2:0] addr,    // byte address / 2
  input  logic [7:0]                     wr_data,
  output logic [7:0]                     rd_data
);

  logic [7:0] mem [0:(2**(soc_pkg::addr_width-1))-1]; // 2 KiB per bank

  always_ff @(posedge sys_clk) begin
    if (wr)
      mem[addr] <= wr_data;
    rd_data <= mem[addr]; // old data on a same-cycle write
  end

endmodule

/* source/word_loader.sv */
`timescale 1ns/1ps

// packs serial bytes into 16-bit words, high byte first,
// and writes them upward from load_base until the end mark
module word_loader (
  input  logic                         sys_clk,
  input  logic                         rst_n,
  input  logic [7:0]                   rx_byte,
  input  logic                         rx_byte_v,  // one cycle per byte
  output logic                         ld_wr,
  output logic [soc_pkg::addr_width-1:0] ld_addr,
  output logic [15:0]                  ld_data,
  output logic                         load_done,
  output logic [15:0]                  word0,      // newest
  output logic [15:0]                  word1,
  output logic [15:0]                  word2       // oldest
);

  logic        phase;      // 0 waits for high byte, 1 for low byte
  logic        byte_take;
  logic        word_done;
  logic        is_mark;
  logic [15:0] next_word;

  assign byte_take = rx_byte_v & ~load_done;  // bytes after the mark are dropped
  assign word_done = byte_take & phase;
  assign next_word = {ld_data[7:0], rx_byte}; // shift in new byte
  assign is_mark   = (next_word == soc_pkg::end_mark);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      phase <= 1'b0;
    else if (byte_take)
      phase <= ~phase;
  end

  // assembly register, doubles as write data
  always_ff @(posedge sys_clk) begin
    if (byte_take)
      ld_data <= next_word;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_wr     <= 1'b0;
      load_done <= 1'b0;
    end else begin
      ld_wr <= word_done & ~is_mark; // one cycle after the low byte
      if (word_done && is_mark)
        load_done <= 1'b1;           // sticky until reset
    end
  end

  // next free word address
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      ld_addr <= soc_pkg::load_base;
    else if (ld_wr)
      ld_addr <= ld_addr + soc_pkg::addr_width'(2);
  end

  // last three stored words for the display
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      word0 <= 16'd0;
      word1 <= 16'd0;
      word2 <= 16'd0;
    end else if (word_done && !is_mark) begin
      word2 <= word1;
      word1 <= word0;
      word0 <= next_word;
    end
  end

endmodule

/* source/memory_io.sv */
`timescale 1ns/1ps

// bus arbitration, two byte banks, led/lcd registers and read mux
// little endian: byte A is word bits 7:0, byte A+1 is bits 15:8
module memory_io (
  input  logic                           sys_clk,
  input  logic                           rst_n,
  input  logic                           ld_wr,
  input  logic [soc_pkg::addr_width-1:0] ld_addr,
  input  logic [15:0]                    ld_data,
  input  logic                           load_done,
  input  logic [soc_pkg::addr_width-1:0] cpu_addr,
  input  logic                           cpu_wr,
  input  logic                           cpu_byt,
  input  logic [15:0]                    cpu_wr_data,
  output logic [15:0]                    cpu_rd_data,
  output logic [soc_pkg::addr_width-1:0] bus_addr,
  output logic [7:0]                     io_led,
  output logic [7:0]                     io_lcd
);

  logic                           wr;
  logic                           byt;
  logic                           odd;
  logic                           io_hit;
  logic                           ram_wr;
  soc_pkg::bus_word_u             wr_word;
  logic                           wr_lo;
  logic                           wr_hi;
  logic [soc_pkg::addr_width-2:0] idx_lo;
  logic [soc_pkg::addr_width-2:0] idx_hi;
  logic [7:0]                     data_lo;
  logic [7:0]                     data_hi;
  logic [7:0]                     rd_lo;
  logic [7:0]                     rd_hi;
  logic [soc_pkg::addr_width-1:0] rd_addr_q;
  logic                           rd_io;
  logic                           rd_io_reg;

  // loader owns the bus until load_done, cpu afterwards
  assign bus_addr      = load_done ? cpu_addr : ld_addr;
  assign wr            = load_done ? cpu_wr : ld_wr;
  assign byt           = load_done & cpu_byt; // loader always writes words
  assign wr_word.whole = load_done ? cpu_wr_data : ld_data;

  assign odd    = bus_addr[0];
  assign io_hit = (bus_addr & soc_pkg::io_region_mask) == soc_pkg::io_region;
  assign ram_wr = wr & ~io_hit; // io window never reaches ram

  // odd address: byte A sits in the hi bank, byte A+1 in the next lo row
  assign idx_hi = bus_addr[soc_pkg::addr_width-1:1];
  assign idx_lo = bus_addr[soc_pkg::addr_width-1:1] + {{(soc_pkg::addr_width-2){1'b0}}, odd};

  assign wr_lo   = ram_wr & (~byt | ~odd);
  assign wr_hi   = ram_wr & (~byt | odd);
  assign data_lo = odd ? wr_word.bytes[1] : wr_word.bytes[0];
  assign data_hi = odd ? wr_word.bytes[0] : wr_word.bytes[1]; // byte write: low byte

  byte_bank_ram u_bank_lo (   // even bytes
    .sys_clk (sys_clk),
    .wr      (wr_lo),
    .addr    (idx_lo),
    .wr_data (data_lo),
    .rd_data (rd_lo)
  );

  byte_bank_ram u_bank_hi (   // odd bytes
    .sys_clk (sys_clk),
    .wr      (wr_hi),
    .addr    (idx_hi),
    .wr_data (data_hi),
    .rd_data (rd_hi)
  );

  // io registers
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_led <= 8'd0;
      io_lcd <= 8'd0;
    end else if (wr && bus_addr == soc_pkg::io_led_addr) begin
      if (byt)
        io_led <= wr_word.bytes[0];         // led only
      else
        {io_lcd, io_led} <= wr_word.whole;  // both bytes
    end else if (wr && bus_addr == soc_pkg::io_lcd_addr) begin
      io_lcd <= wr_word.bytes[0];           // byte 0x081 is the low byte
    end
  end

  // read address follows the bank read by one cycle
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      rd_addr_q <= '0;
    else
      rd_addr_q <= bus_addr;
  end

  assign rd_io     = (rd_addr_q & soc_pkg::io_region_mask) == soc_pkg::io_region;
  assign rd_io_reg = rd_addr_q[soc_pkg::addr_width-1:1] ==
                     soc_pkg::io_led_addr[soc_pkg::addr_width-1:1]; // 0x080/0x081

  always_comb begin
    if (rd_io_reg)
      cpu_rd_data = {io_lcd, io_led};
    else if (rd_io)
      cpu_rd_data = 16'd0;       // rest of io window reads zero
    else if (rd_addr_q[0])
      cpu_rd_data = {rd_lo, rd_hi}; // unaligned, lanes swapped
    else
      cpu_rd_data = {rd_hi, rd_lo};
  end

endmodule

/* source/led_matrix_scan.sv */
`timescale 1ns/1ps

// 9-row led matrix, active-low rows, one row lit at a time
module led_matrix_scan #(
  parameter logic [15:0] scan_period = soc_pkg::scan_period,
  parameter logic [15:0] gap_on      = soc_pkg::gap_on,
  parameter logic [15:0] gap_off     = soc_pkg::gap_off
) (
  input  logic                           sys_clk,
  input  logic                           rst_n,
  input  logic [15:0]                    word0,
  input  logic [15:0]                    word1,
  input  logic [15:0]                    word2,
  input  logic [soc_pkg::addr_width-1:0] bus_addr,
  input  logic                           load_done,
  output logic [7:0]                     led_col,
  output logic [soc_pkg::row_count-1:0]  led_row
);

  logic [15:0]                   row_timer;
  logic [3:0]                    row_index;
  logic                          row_on;
  logic [soc_pkg::row_count-1:0] row_sel;
  soc_pkg::bus_word_u            w0;
  soc_pkg::bus_word_u            w1;
  soc_pkg::bus_word_u            w2;

  // segments a..g then dp, a is bit 7
  function automatic logic [7:0] seg7(input logic [3:0] digit, input logic dp);
    logic [6:0] seg;
    case (digit)
      4'h0:    seg = 7'b1111110;
      4'h1:    seg = 7'b0110000;
      4'h2:    seg = 7'b1101101;
      4'h3:    seg = 7'b1111001;
      4'h4:    seg = 7'b0110011;
      4'h5:    seg = 7'b1011011;
      4'h6:    seg = 7'b1011111;
      4'h7:    seg = 7'b1110010;
      4'h8:    seg = 7'b1111111;
      4'h9:    seg = 7'b1111011;
      4'ha:    seg = 7'b1110111;
      4'hb:    seg = 7'b0011111;
      4'hc:    seg = 7'b1001110;
      4'hd:    seg = 7'b0111101;
      4'he:    seg = 7'b1001111;
      default: seg = 7'b1000111; // f
    endcase
    return {seg, dp};
  endfunction

  // row timer, 0 .. scan_period-1
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      row_timer <= 16'd0;
    else if (row_timer >= scan_period - 16'd1)
      row_timer <= 16'd0;
    else
      row_timer <= row_timer + 16'd1;
  end

  // next row when the timer wraps
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      row_index <= 4'd0;
    end else if (row_timer >= scan_period - 16'd1) begin
      if (row_index < 4'(soc_pkg::row_count - 1))
        row_index <= row_index + 4'd1;
      else
        row_index <= 4'd0;
    end
  end

  // dark at both ends of a row so neighbours don't ghost
  assign row_on  = (row_timer >= gap_on) && (row_timer < scan_period - gap_off);
  assign row_sel = {{(soc_pkg::row_count-1){1'b0}}, row_on} << row_index;
  assign led_row = ~row_sel; // active low

  assign w0 = word0;
  assign w1 = word1;
  assign w2 = word2;

  always_comb begin
    case (row_index)
      4'd0:    led_col = w0.bytes[1];
      4'd1:    led_col = w0.bytes[0];
      4'd2:    led_col = w1.bytes[1];
      4'd3:    led_col = w1.bytes[0];
      4'd4:    led_col = w2.bytes[1];
      4'd5:    led_col = w2.bytes[0];
      4'd6:    led_col = {load_done, 3'd0, bus_addr[11:8]};
      4'd7:    led_col = bus_addr[7:0];
      4'd8:    led_col = seg7(bus_addr[3:0], bus_addr[4]); // bit 4 on the dp
      default: led_col = 8'd0;
    endcase
  end

endmodule

/* source/board_top.sv */
`timescale 1ns/1ps

// memory and display side of the board, cpu bus on the ports
module board_top #(
  parameter logic [15:0] scan_period = soc_pkg::scan_period,
  parameter logic [15:0] gap_on      = soc_pkg::gap_on,
  parameter logic [15:0] gap_off     = soc_pkg::gap_off
) (
  input  logic                           sys_clk,
  input  logic                           rst_n,
  input  logic [7:0]                     rx_byte,     // from uart receiver
  input  logic                           rx_byte_v,
  input  logic [soc_pkg::addr_width-1:0] cpu_addr,
  input  logic                           cpu_wr,
  input  logic                           cpu_byt,
  input  logic [15:0]                    cpu_wr_data,
  output logic [15:0]                    cpu_rd_data,
  output logic                           load_done,
  output logic [7:0]                     led_col,
  output logic [soc_pkg::row_count-1:0]  led_row,
  output logic                           lcd_e,
  output logic                           lcd_rw,
  output logic                           lcd_rs,
  output logic [3:0]                     lcd_db       // 4-bit lcd bus
);

  logic                           ld_wr;
  logic [soc_pkg::addr_width-1:0] ld_addr;
  logic [15:0]                    ld_data;
  logic [15:0]                    word0;
  logic [15:0]                    word1;
  logic [15:0]                    word2;
  logic [soc_pkg::addr_width-1:0] bus_addr;
  logic [7:0]                     io_lcd;

  word_loader u_loader (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .rx_byte   (rx_byte),
    .rx_byte_v (rx_byte_v),
    .ld_wr     (ld_wr),
    .ld_addr   (ld_addr),
    .ld_data   (ld_data),
    .load_done (load_done),
    .word0     (word0),
    .word1     (word1),
    .word2     (word2)
  );

  memory_io u_mem (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .ld_wr       (ld_wr),
    .ld_addr     (ld_addr),
    .ld_data     (ld_data),
    .load_done   (load_done),
    .cpu_addr    (cpu_addr),
    .cpu_wr      (cpu_wr),
    .cpu_byt     (cpu_byt),
    .cpu_wr_data (cpu_wr_data),
    .cpu_rd_data (cpu_rd_data),
    .bus_addr    (bus_addr),
    .io_led      (),          // no pin, read back over the bus
    .io_lcd      (io_lcd)
  );

  led_matrix_scan #(
    .scan_period (scan_period),
    .gap_on      (gap_on),
    .gap_off     (gap_off)
  ) u_scan (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .word0     (word0),
    .word1     (word1),
    .word2     (word2),
    .bus_addr  (bus_addr),
    .load_done (load_done),
    .led_col   (led_col),
    .led_row   (led_row)
  );

  // lcd control and data nibble straight from the register
  assign lcd_e  = io_lcd[0];
  assign lcd_rw = io_lcd[1];
  assign lcd_rs = io_lcd[2];
  assign lcd_db = io_lcd[7:4]; // bit 3 unused

endmodule

/* sim/board_props.sv */
`timescale 1ns/1ps

// bus ownership and display rules, bound into memory_io and led_matrix_scan
module board_props #(
  parameter bit scan_side = 1'b0 // display rules when set, bus rules otherwise
) (
  input logic                          sys_clk,
  input logic                          rst_n,
  input logic                          ld_wr,
  input logic                          load_done,
  input logic [7:0]                    io_led,
  input logic [7:0]                    io_lcd,
  input logic [soc_pkg::row_count-1:0] led_row
);

  int unsigned fail_cnt = 0;

  if (scan_side) begin : g_scan
    one_row_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
      $countones(~led_row) <= 1)
      else begin
        $error("led_row %b has more than one low bit", led_row);
        fail_cnt++;
      end
  end else begin : g_bus
    no_load_after_done_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !(ld_wr && load_done))
      else begin
        $error("ld_wr high while load_done is set");
        fail_cnt++;
      end

    // lcd pins come straight from io_lcd
    io_reset_a: assert property (@(posedge sys_clk)
      (!rst_n || $rose(rst_n)) |-> (io_led == 8'd0 && io_lcd == 8'd0))
      else begin
        $error("io registers not cleared by reset");
        fail_cnt++;
      end
  end

endmodule

bind memory_io board_props #(.scan_side (1'b0)) u_props (
  .sys_clk (sys_clk), .rst_n (rst_n), .ld_wr (ld_wr), .load_done (load_done),
  .io_led (io_led), .io_lcd (io_lcd), .led_row ('1)
);

bind led_matrix_scan board_props #(.scan_side (1'b1)) u_props (
  .sys_clk (sys_clk), .rst_n (rst_n), .ld_wr (1'b0), .load_done (load_done),
  .io_led (8'd0), .io_lcd (8'd0), .led_row (led_row)
);

/* sim/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

  localparam int n_words     = 12;
  localparam int scan_len    = 40;
  localparam int cycle_limit = 6000; // tests need about 1000 cycles

  // a..g codes for digits 0..f, a in the msb, seven drawn with segment f
  localparam logic [6:0] seg_tab [16] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h72,
                                          7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};

  logic                           sys_clk = 1'b0;
  logic                           rst_n;
  logic [7:0]                     rx_byte;
  logic                           rx_byte_v;
  logic [soc_pkg::addr_width-1:0] cpu_addr;
  logic                           cpu_wr;
  logic                           cpu_byt;
  logic [15:0]                    cpu_wr_data;
  logic [15:0]                    cpu_rd_data;
  logic                           load_done;
  logic [7:0]                     led_col;
  logic [soc_pkg::row_count-1:0]  led_row;
  logic                           lcd_e;
  logic                           lcd_rw;
  logic                           lcd_rs;
  logic [3:0]                     lcd_db;

  logic [7:0]  mem_m [0:4095]; // model, x until written like the banks
  logic [7:0]  led_m;
  logic [7:0]  lcd_m;
  logic [15:0] hist [0:2];     // newest first
  logic        done_m;
  logic        rd_req;         // read pipeline toward the comparator
  logic        rd_req_q;
  logic [15:0] rd_exp;
  logic [15:0] rd_exp_q;
  logic [11:0] rd_addr;
  logic [11:0] rd_addr_q;
  logic        scan_on;
  logic [8:0]  rows_seen;
  int          rd_errs = 0;
  int          pin_errs = 0;
  int          scan_errs = 0;
  int          cycles = 0;

  board_top #(.scan_period(16'd40), .gap_on(16'd2), .gap_off(16'd8)) u_dut (
    .sys_clk (sys_clk), .rst_n (rst_n), .rx_byte (rx_byte), .rx_byte_v (rx_byte_v),
    .cpu_addr (cpu_addr), .cpu_wr (cpu_wr), .cpu_byt (cpu_byt), .cpu_wr_data (cpu_wr_data),
    .cpu_rd_data (cpu_rd_data), .load_done (load_done), .led_col (led_col),
    .led_row (led_row), .lcd_e (lcd_e), .lcd_rw (lcd_rw), .lcd_rs (lcd_rs), .lcd_db (lcd_db)
  );

  always #20 sys_clk = ~sys_clk;

  // little endian, 0x080/0x081 read the io pair, rest of 0x080..0x0ff reads 0
  function automatic logic [15:0] expected_read(input logic [11:0] a);
    if (a[11:1] == 11'h040)
      return {lcd_m, led_m};
    else if (a >= 12'h080 && a <= 12'h0ff)
      return 16'h0000;
    return {mem_m[a + 12'd1], mem_m[a]};
  endfunction

  function automatic void model_write(input logic byt, input logic [11:0] a, input logic [15:0] d);
    if (!done_m)
      return;                      // loader owns the bus
    if (a == 12'h080 && byt)
      led_m = d[7:0];
    else if (a == 12'h080)
      {lcd_m, led_m} = d;
    else if (a == 12'h081)
      lcd_m = d[7:0];
    else if (a < 12'h080 || a > 12'h0ff) begin
      mem_m[a] = d[7:0];
      if (!byt)
        mem_m[a + 12'd1] = d[15:8];
    end
  endfunction

  function automatic logic [7:0] expected_col(input int row, input logic [11:0] a);
    case (row)
      0:       return hist[0][15:8];
      1:       return hist[0][7:0];
      2:       return hist[1][15:8];
      3:       return hist[1][7:0];
      4:       return hist[2][15:8];
      5:       return hist[2][7:0];
      6:       return {done_m, 3'b000, a[11:8]};
      7:       return a[7:0];
      default: return {seg_tab[a[3:0]], a[4]}; // digit plus dp
    endcase
  endfunction

  task automatic send_byte(input logic [7:0] b);
    @(posedge sys_clk);
    rx_byte     <= b;
    rx_byte_v   <= 1'b1;
    cpu_wr      <= 1'b1;           // stray cpu write, must be dropped
    cpu_byt     <= 1'($urandom);
    cpu_wr_data <= 16'($urandom);
    if ($urandom % 2)
      cpu_addr <= soc_pkg::io_led_addr;
    else
      cpu_addr <= soc_pkg::load_base + 12'($urandom % 32);
    @(posedge sys_clk);
    rx_byte_v <= 1'b0;
    cpu_wr    <= 1'b0;
  endtask

  task automatic bus_write(input logic byt, input logic [11:0] a, input logic [15:0] d);
    @(posedge sys_clk);
    cpu_wr      <= 1'b1;
    cpu_byt     <= byt;
    cpu_addr    <= a;
    cpu_wr_data <= d;
    rd_req      <= 1'b0;
    model_write(byt, a, d);
  endtask

  task automatic bus_read(input logic [11:0] a);
    @(posedge sys_clk);
    cpu_wr   <= 1'b0;
    cpu_addr <= a;
    rd_req   <= 1'b1;
    rd_exp   <= expected_read(a);
    rd_addr  <= a;
  endtask

  task automatic bus_idle();
    @(posedge sys_clk);
    cpu_wr <= 1'b0;
    rd_req <= 1'b0;
  endtask

  task automatic check_lcd_pins();
    @(negedge sys_clk);
    if ({lcd_db, lcd_rs, lcd_rw, lcd_e} !== {lcd_m[7:4], lcd_m[2:0]}) begin
      pin_errs++;
      $display("FAILED t=%0t lcd_db/rs/rw/e exp %b got %b", $time,
               {lcd_m[7:4], lcd_m[2:0]}, {lcd_db, lcd_rs, lcd_rw, lcd_e});
    end
  endtask

  always @(posedge sys_clk) begin
    rd_req_q  <= rd_req;
    rd_exp_q  <= rd_exp;
    rd_addr_q <= rd_addr;
  end

  // read data is one cycle behind the address, stable at the falling edge
  always @(negedge sys_clk) begin
    if (rd_req_q && cpu_rd_data !== rd_exp_q) begin
      rd_errs++;
      $display("FAILED t=%0t cpu_rd_data at %h exp %h got %h",
               $time, rd_addr_q, rd_exp_q, cpu_rd_data);
    end
  end

  always @(negedge sys_clk) begin : scan_check
    int row;
    row = 0;
    for (int r = 0; r < soc_pkg::row_count; r++)
      if (!led_row[r])
        row = r;
    if (scan_on && $countones(led_row) == soc_pkg::row_count - 1) begin
      rows_seen[row] = 1'b1;
      if (led_col !== expected_col(row, cpu_addr)) begin
        scan_errs++;
        $display("FAILED t=%0t led_col row %0d exp %h got %h",
                 $time, row, expected_col(row, cpu_addr), led_col);
      end
    end
  end

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    logic [15:0] w;
    logic [11:0] a;
    int          prop_fails;
    void'($urandom(32'h32e2));
    rst_n       = 1'b0;
    rx_byte     = 8'd0;
    rx_byte_v   = 1'b0;
    cpu_addr    = '0;
    cpu_wr      = 1'b0;
    cpu_byt     = 1'b0;
    cpu_wr_data = 16'd0;
    rd_req      = 1'b0;
    rd_exp      = 16'd0;
    rd_addr     = 12'd0;
    done_m      = 1'b0;
    led_m       = 8'd0;
    lcd_m       = 8'd0;
    scan_on     = 1'b0;
    rows_seen   = '0;
    repeat (7) @(posedge sys_clk);
    @(negedge sys_clk);
    if ({load_done, led_row, lcd_e, lcd_rw, lcd_rs, lcd_db} !== {1'b0, 9'h1ff, 7'd0}) begin
      pin_errs++;
      $display("FAILED t=%0t load_done/led_row/lcd pins exp %b got %b", $time,
               {1'b0, 9'h1ff, 7'd0}, {load_done, led_row, lcd_e, lcd_rw, lcd_rs, lcd_db});
    end
    @(posedge sys_clk);
    rst_n <= 1'b1;

    // load, high byte first
    for (int i = 0; i < n_words; i++) begin
      w = 16'($urandom);
      while (w == soc_pkg::end_mark)
        w = 16'($urandom);
      send_byte(w[15:8]);
      send_byte(w[7:0]);
      a = soc_pkg::load_base + 12'(2 * i);
      mem_m[a]         = w[7:0];
      mem_m[a + 12'd1] = w[15:8];
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = w;
    end
    send_byte(soc_pkg::end_mark[15:8]);
    send_byte(soc_pkg::end_mark[7:0]);
    @(negedge sys_clk);
    if (load_done !== 1'b1) begin
      pin_errs++;
      $display("FAILED t=%0t load_done exp 1 got %b", $time, load_done);
    end
    done_m = 1'b1;

    for (int i = 0; i <= n_words; i++)
      bus_read(soc_pkg::load_base + 12'(2 * i)); // last one must not hold the mark
    bus_read(soc_pkg::io_led_addr); // stray writes left the io pair cleared
    bus_write(1'b0, a + 12'd2, 16'($urandom));
    bus_read(a + 12'd2);

    // word and byte writes below the load area, then the word and its neighbour
    repeat (24) begin
      a = 12'h100 + 12'($urandom % 12'h1fe);
      bus_write(1'($urandom), a, 16'($urandom));
      bus_read(a);
      bus_read(a ^ 12'd1);
    end

    bus_write(1'b0, soc_pkg::io_led_addr, 16'($urandom));
    bus_idle();
    check_lcd_pins();
    bus_read(soc_pkg::io_led_addr);
    bus_write(1'b1, soc_pkg::io_led_addr, 16'($urandom));
    bus_read(soc_pkg::io_led_addr);
    bus_write(1'b0, soc_pkg::io_lcd_addr, 16'($urandom));
    bus_read(soc_pkg::io_lcd_addr);
    bus_idle();
    check_lcd_pins();
    bus_write(1'b0, 12'h0ff, 16'($urandom)); // must not spill into 0x100
    bus_read(12'h100);
    repeat (8) begin
      a = 12'h082 + 12'($urandom % 126);
      bus_write(1'($urandom), a, 16'($urandom));
      bus_read(a);
    end

    // display scan with the bus address held
    bus_read(12'($urandom));
    bus_idle();
    scan_on = 1'b1;
    repeat (20 * scan_len) @(posedge sys_clk);
    scan_on = 1'b0;
    if (rows_seen !== 9'h1ff) begin
      scan_errs++;
      $display("not every display row lit within 20 scan periods, seen %b", rows_seen);
    end

    prop_fails = u_dut.u_mem.u_props.fail_cnt + u_dut.u_scan.u_props.fail_cnt;
    $display("errors: read %0d, pins %0d, display %0d, assertions %0d",
             rd_errs, pin_errs, scan_errs, prop_fails);
    if (rd_errs + pin_errs + scan_errs + prop_fails == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* vlog.f */
source/soc_pkg.sv
source/byte_bank_ram.sv
source/word_loader.sv
source/memory_io.sv
source/led_matrix_scan.sv
source/board_top.sv
sim/board_props.sv
sim/tb_board_top.sv
